// File: sim.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_core.sv
tb/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_alu.sv
  - source/rv_core.sv
  - target: test
    files:
      - tb/tb_rv_core.sv

// File: tb/tb_rv_core.sv
/* Testbench for the four-stage RV32I core
   Random program checked store by store against an in-order reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam int clk_period     = 20;
    localparam int prog_len       = 200;
    localparam int last_idx       = prog_len - 1;
    localparam int drain_cycles   = 50;
    localparam int timeout_cycles = prog_len * 20 + drain_cycles + 10;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_if_valid;
    logic                   i_mem_valid;
    logic [xlen-1:0]        i_data_in;
    logic [instr_width-1:0] i_instr;
    logic [xlen-1:0]        o_pc_out;
    logic                   o_store_req;
    logic                   o_load_req;
    logic [xlen-1:0]        o_data_addr;
    logic [xlen-1:0]        o_data_out;

    // Instruction memory at address 0, data region of 256 words at 0x400
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] model_dmem [0:255];
    logic [31:0] model_regs [0:31];
    logic        filled [0:255];
    logic [31:0] exp_addr [0:255];
    logic [31:0] exp_data [0:255];
    int          n_stores;
    int          store_idx;
    int          load_delay;
    int          drain;
    logic [31:0] rng_state;

    // Same-cycle instruction read
    assign i_instr = imem[o_pc_out[9:2]];

    rv_core uut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_if_valid  (i_if_valid),
        .i_instr     (i_instr),
        .i_mem_valid (i_mem_valid),
        .i_data_in   (i_data_in),
        .o_pc_out    (o_pc_out),
        .o_store_req (o_store_req),
        .o_load_req  (o_load_req),
        .o_data_addr (o_data_addr),
        .o_data_out  (o_data_out)
    );

    initial begin
        i_clk = 1'b0;
        forever #(clk_period / 2) i_clk = ~i_clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // One of x1..x7
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand() % 7 + 1;
        return r[4:0];
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // RV32I integer semantics, alt selects SUB or SRA
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sra_val;
        sra_val = $signed(a) >>> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra_val : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h (store %0d)",
                                      name, actual, expected, store_idx));
        end
    endtask

    // Store the link register at the jump target
    task automatic plant_link_store(input int tgt, input logic [4:0] rd);
        logic [31:0] r;
        r = next_rand();
        if (tgt < last_idx && !filled[tgt]) begin
            imem[tgt]   = s_type(12'h400 + {2'b00, r[7:0], 2'b00}, rd, 5'd0);
            filled[tgt] = 1'b1;
        end
    endtask

    task automatic build_program();
        int          i;
        int          pos;
        int          kind;
        int          tgt;
        int          delta;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rb;
        logic [4:0]  rs_a;
        logic [4:0]  rs_b;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [11:0] off;
        // Unused words hold ADDI x0 with the word index as immediate
        for (i = 0; i < 256; i++) begin
            imem[i]   = i_type(i[11:0], 5'd0, 3'd0, 5'd0, op_imm);
            filled[i] = 1'b0;
            dmem[i]   = next_rand();
        end
        for (i = 1; i <= 7; i++) begin
            r = next_rand();
            imem[2*i-2] = u_type(r[31:12], i[4:0]);
            imem[2*i-1] = i_type(r[11:0], i[4:0], 3'd0, i[4:0], op_imm);
        end
        // Final spin loop
        imem[last_idx] = j_type(21'd0, 5'd0);
        pos = 14;
        while (pos < last_idx) begin
            if (!filled[pos]) begin
                r    = next_rand();
                kind = r[3:0];
                f3   = r[6:4];
                rd   = pick_reg();
                rs_a = pick_reg();
                rs_b = pick_reg();
                tgt  = pos + 2 + r[6:4];
                if (tgt > last_idx) begin
                    tgt = last_idx;
                end
                delta = (tgt - pos) * 4;
                if (kind <= 4) begin
                    alt       = r[7] && (f3 == 3'd0 || f3 == 3'd5);
                    imem[pos] = r_type({1'b0, alt, 5'd0}, rs_b, rs_a, f3, rd);
                end else if (kind <= 7) begin
                    imm = r[31:20];
                    if (f3 == 3'd1) begin
                        imm = {7'd0, r[24:20]};
                    end else if (f3 == 3'd5) begin
                        imm = {1'b0, r[7], 5'd0, r[24:20]};
                    end
                    imem[pos] = i_type(imm, rs_a, f3, rd, op_imm);
                end else if (kind == 8) begin
                    imem[pos] = u_type(r[31:12], rd);
                end else if (kind <= 11) begin
                    rb  = 5'd0;
                    off = 12'h400 + {2'b00, r[27:20], 2'b00};
                    // Sometimes compute the base in the instruction just before
                    if (r[8] && pos + 1 < last_idx && !filled[pos + 1]) begin
                        rb        = rs_a;
                        imem[pos] = i_type(12'h400 + {3'b000, r[26:20], 2'b00}, 5'd0, 3'd0,
                                           rb, op_imm);
                        off       = {3'b000, r[15:9], 2'b00};
                        pos++;
                    end
                    if (kind == 11) begin
                        imem[pos] = i_type(off, rb, 3'b010, rd, op_load);
                    end else begin
                        imem[pos] = s_type(off, rs_b, rb);
                    end
                end else if (kind <= 13) begin
                    imem[pos] = b_type(delta[12:0], rs_b, rs_a, {2'b00, r[7]});
                end else if (kind == 14) begin
                    imem[pos] = j_type(delta[20:0], rd);
                    plant_link_store(tgt, rd);
                end else if (pos + 1 < last_idx && !filled[pos + 1]) begin
                    // LUI of the zero page, then JALR with an odd offset at times
                    tgt = pos + 3 + r[6:4];
                    if (tgt > last_idx) begin
                        tgt = last_idx;
                    end
                    delta     = tgt * 4 + r[7];
                    imem[pos] = u_type(20'd0, rs_a);
                    pos++;
                    imem[pos] = i_type(delta[11:0], rs_a, 3'd0, rd, op_jalr);
                    plant_link_store(tgt, rd);
                end else begin
                    imem[pos] = i_type(12'd1, rd, 3'd0, rd, op_imm);
                end
            end
            pos++;
        end
    endtask

    // Sequential execution, records every store in program order
    task automatic run_model();
        int          i;
        int          steps;
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] wval;
        logic [31:0] addr;
        logic        wen;
        for (i = 0; i < 256; i++) begin
            model_dmem[i] = dmem[i];
        end
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        pc       = pc_start;
        steps    = 0;
        n_stores = 0;
        while (pc != last_idx * 4 && steps < 2 * prog_len) begin
            ins     = imem[pc[9:2]];
            a       = model_regs[ins[19:15]];
            b       = model_regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wen     = 1'b1;
            wval    = pc + 4;
            next_pc = pc + 4;
            case (ins[6:0])
                op_reg:  wval = model_alu(ins[14:12], ins[30], a, b);
                op_imm:  wval = model_alu(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
                op_lui:  wval = {ins[31:12], 12'h000};
                op_load: begin
                    addr = a + imm_i;
                    wval = model_dmem[addr[9:2]];
                end
                op_store: begin
                    wen                  = 1'b0;
                    addr                 = a + imm_s;
                    exp_addr[n_stores]   = addr;
                    exp_data[n_stores]   = b;
                    n_stores             = n_stores + 1;
                    model_dmem[addr[9:2]] = b;
                end
                op_branch: begin
                    wen = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + imm_b;
                    end
                end
                op_jal:  next_pc = pc + imm_j;
                op_jalr: next_pc = (a + imm_i) & 32'hffff_fffe;
                default: wen = 1'b0;
            endcase
            if (wen && ins[11:7] != 5'd0) begin
                model_regs[ins[11:7]] = wval;
            end
            pc    = next_pc;
            steps = steps + 1;
        end
        if (pc != last_idx * 4) begin
            stop_with_error("reference model did not reach the end of the program");
        end
    endtask

    initial begin
        rng_state   = 32'h98ee_237f;
        i_reset     = 1'b1;
        i_if_valid  = 1'b0;
        i_mem_valid = 1'b0;
        i_data_in   = '0;
        store_idx   = 0;
        drain       = drain_cycles;
        build_program();
        run_model();
        load_delay = next_rand() % 4;
        repeat (4) @(posedge i_clk);
        i_reset    <= 1'b0;
        i_if_valid <= 1'b1;
        @(negedge i_clk);
        check_value("o_pc_out", o_pc_out, pc_start);
        check_value("o_store_req", {31'd0, o_store_req}, 32'd0);
        check_value("o_load_req", {31'd0, o_load_req}, 32'd0);
        // Outputs sampled at the edge hold the values of the cycle just ended
        while (drain > 0) begin
            @(posedge i_clk);
            if (o_store_req) begin
                if (store_idx >= n_stores) begin
                    stop_with_error("store request seen after the last expected store");
                end else begin
                    check_value("o_data_addr", o_data_addr, exp_addr[store_idx]);
                    check_value("o_data_out", o_data_out, exp_data[store_idx]);
                    dmem[o_data_addr[9:2]] = o_data_out;
                    store_idx = store_idx + 1;
                end
            end
            // Load responder with 0 to 3 extra wait cycles
            if (o_load_req) begin
                if (i_mem_valid) begin
                    i_mem_valid <= 1'b0;
                    load_delay = next_rand() % 4;
                end else if (load_delay == 0) begin
                    i_mem_valid <= 1'b1;
                    i_data_in   <= dmem[o_data_addr[9:2]];
                end else begin
                    load_delay = load_delay - 1;
                end
            end
            i_if_valid <= (next_rand() % 5) != 0;
            if (store_idx == n_stores) begin
                drain = drain - 1;
            end
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        stop_with_error($sformatf("timeout, only %0d of %0d expected stores appeared",
                                  store_idx, n_stores));
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
/* Four-stage in-order RV32I core
   Fetch/decode, execute, memory and writeback with forwarding and stalls */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                            i_clk,
    input  wire                            i_reset,
    input  wire                            i_if_valid,
    input  wire  [rv_pkg::instr_width-1:0] i_instr,
    input  wire                            i_mem_valid,
    input  wire  [rv_pkg::xlen-1:0]        i_data_in,
    output logic [rv_pkg::xlen-1:0]        o_pc_out,
    output logic                           o_store_req,
    output logic                           o_load_req,
    output logic [rv_pkg::xlen-1:0]        o_data_addr,
    output logic [rv_pkg::xlen-1:0]        o_data_out
);
    import rv_pkg::*;

    // Fetch and IF/ID
    logic [xlen-1:0]           pc_q;
    logic [instr_width-1:0]    instr_id;
    logic [xlen-1:0]           pc_id;

    // Decode outputs
    alu_op_e                   dec_alu_op;
    logic                      dec_src_a_pc, dec_src_b_imm;
    logic                      dec_reg_write, dec_mem_write, dec_mem_to_reg;
    logic                      dec_branch, dec_branch_ne, dec_jump, dec_jalr;
    logic [xlen-1:0]           dec_imm;
    logic [reg_addr_width-1:0] dec_rs1_addr, dec_rs2_addr, dec_rd_addr;
    logic [xlen-1:0]           rf_rs1_data, rf_rs2_data;
    logic [xlen-1:0]           id_rs1_val, id_rs2_val;

    // ID/EX
    alu_op_e                   ex_alu_op;
    logic                      ex_src_a_pc, ex_src_b_imm;
    logic                      ex_reg_write, ex_mem_write, ex_mem_to_reg;
    logic                      ex_branch, ex_branch_ne, ex_jump, ex_jalr;
    logic [xlen-1:0]           ex_imm, ex_pc, ex_rs1_val, ex_rs2_val;
    logic [reg_addr_width-1:0] ex_rs1_addr, ex_rs2_addr, ex_rd_addr;
    logic [xlen-1:0]           ex_rs1_fwd, ex_rs2_fwd, alu_a, alu_b, alu_result;
    logic [xlen-1:0]           ex_target_sum, ex_target;
    logic                      ex_br_taken;

    // EX/MEM and MEM/WB
    logic                      mem_reg_write, mem_mem_write, mem_mem_to_reg;
    logic                      mem_br_taken, mem_jump;
    logic [xlen-1:0]           mem_alu_result, mem_rs2_val, mem_target;
    logic [reg_addr_width-1:0] mem_rd_addr;
    logic                      wb_reg_write, wb_mem_to_reg;
    logic [xlen-1:0]           wb_alu_result, wb_load_data, wb_result;
    logic [reg_addr_width-1:0] wb_rd_addr;

    // Hazard control
    logic pc_jump, load_hazard, load_wait;
    logic pc_stall, id_stall, ex_stall, mem_stall;
    logic id_flush, ex_flush, mem_flush, wb_flush;

    // Static not-taken prediction, redirect resolved in memory stage
    assign pc_jump     = mem_br_taken || mem_jump;
    assign load_hazard = ex_mem_to_reg &&
                         ((dec_rs1_addr == ex_rd_addr) || (dec_rs2_addr == ex_rd_addr));
    assign load_wait   = o_load_req && !i_mem_valid;

    assign mem_stall = load_wait;
    assign ex_stall  = mem_stall;
    assign id_stall  = ex_stall || load_hazard;
    assign pc_stall  = id_stall || !i_if_valid;
    assign id_flush  = i_reset || pc_jump;
    assign ex_flush  = i_reset || pc_jump;
    assign mem_flush = i_reset || pc_jump;
    assign wb_flush  = i_reset || load_wait;

    // Fetch
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q <= pc_start;
        end else if (pc_jump) begin
            pc_q <= mem_target;
        end else if (!pc_stall) begin
            pc_q <= pc_q + xlen'(4);
        end
    end

    // Empty fetch slot becomes a NOP in decode
    always_ff @(posedge i_clk) begin
        if (id_flush) begin
            instr_id <= nop_instr;
        end else if (!id_stall) begin
            instr_id <= i_if_valid ? i_instr : nop_instr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!id_stall) begin
            pc_id <= pc_q;
        end
    end

    // Decode
    rv_decoder u_decoder (
        .i_instr      (instr_id),
        .o_alu_op     (dec_alu_op),
        .o_src_a_pc   (dec_src_a_pc),
        .o_src_b_imm  (dec_src_b_imm),
        .o_reg_write  (dec_reg_write),
        .o_mem_write  (dec_mem_write),
        .o_mem_to_reg (dec_mem_to_reg),
        .o_branch     (dec_branch),
        .o_branch_ne  (dec_branch_ne),
        .o_jump       (dec_jump),
        .o_jalr       (dec_jalr),
        .o_imm        (dec_imm),
        .o_rs1_addr   (dec_rs1_addr),
        .o_rs2_addr   (dec_rs2_addr),
        .o_rd_addr    (dec_rd_addr)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_write_en (wb_reg_write),
        .i_rd_addr  (wb_rd_addr),
        .i_rd_data  (wb_result),
        .i_rs1_addr (dec_rs1_addr),
        .i_rs2_addr (dec_rs2_addr),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    // Writeback value written this cycle is not yet in the file
    assign id_rs1_val = (wb_reg_write && dec_rs1_addr == wb_rd_addr) ? wb_result : rf_rs1_data;
    assign id_rs2_val = (wb_reg_write && dec_rs2_addr == wb_rd_addr) ? wb_result : rf_rs2_data;

    // ID/EX control, bubble on load-use
    always_ff @(posedge i_clk) begin
        if (ex_flush || (!ex_stall && load_hazard)) begin
            ex_alu_op     <= alu_add;
            ex_src_a_pc   <= 1'b0;
            ex_src_b_imm  <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_branch     <= 1'b0;
            ex_branch_ne  <= 1'b0;
            ex_jump       <= 1'b0;
            ex_jalr       <= 1'b0;
        end else if (!ex_stall) begin
            ex_alu_op     <= dec_alu_op;
            ex_src_a_pc   <= dec_src_a_pc;
            ex_src_b_imm  <= dec_src_b_imm;
            ex_reg_write  <= dec_reg_write;
            ex_mem_write  <= dec_mem_write;
            ex_mem_to_reg <= dec_mem_to_reg;
            ex_branch     <= dec_branch;
            ex_branch_ne  <= dec_branch_ne;
            ex_jump       <= dec_jump;
            ex_jalr       <= dec_jalr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!ex_stall) begin
            ex_imm      <= dec_imm;
            ex_pc       <= pc_id;
            ex_rs1_val  <= id_rs1_val;
            ex_rs2_val  <= id_rs2_val;
            ex_rs1_addr <= dec_rs1_addr;
            ex_rs2_addr <= dec_rs2_addr;
            ex_rd_addr  <= dec_rd_addr;
        end else begin
            // Keep forwarded operands, writeback is emptied while a load waits
            ex_rs1_val  <= ex_rs1_fwd;
            ex_rs2_val  <= ex_rs2_fwd;
        end
    end

    // Execute: memory stage has priority over writeback
    assign ex_rs1_fwd = (mem_reg_write && ex_rs1_addr == mem_rd_addr) ? mem_alu_result :
                        (wb_reg_write && ex_rs1_addr == wb_rd_addr)   ? wb_result      :
                                                                        ex_rs1_val;
    assign ex_rs2_fwd = (mem_reg_write && ex_rs2_addr == mem_rd_addr) ? mem_alu_result :
                        (wb_reg_write && ex_rs2_addr == wb_rd_addr)   ? wb_result      :
                                                                        ex_rs2_val;
    assign alu_a = ex_src_a_pc ? ex_pc : ex_rs1_fwd;
    assign alu_b = ex_src_b_imm ? ex_imm : ex_rs2_fwd;

    rv_alu u_alu (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_op     (ex_alu_op),
        .o_result (alu_result)
    );

    // BEQ/BNE compare through the subtract result
    assign ex_br_taken   = ex_branch && (ex_branch_ne ? (alu_result != '0) : (alu_result == '0));
    assign ex_target_sum = (ex_jalr ? ex_rs1_fwd : ex_pc) + ex_imm;
    assign ex_target     = ex_jalr ? {ex_target_sum[xlen-1:1], 1'b0} : ex_target_sum;

    // EX/MEM
    always_ff @(posedge i_clk) begin
        if (mem_flush) begin
            mem_reg_write  <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
            mem_br_taken   <= 1'b0;
            mem_jump       <= 1'b0;
        end else if (!mem_stall) begin
            mem_reg_write  <= ex_reg_write;
            mem_mem_write  <= ex_mem_write;
            mem_mem_to_reg <= ex_mem_to_reg;
            mem_br_taken   <= ex_br_taken;
            mem_jump       <= ex_jump;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!mem_stall) begin
            mem_alu_result <= alu_result;
            mem_rs2_val    <= ex_rs2_fwd;
            mem_rd_addr    <= ex_rd_addr;
            mem_target     <= ex_target;
        end
    end

    // MEM/WB, bubble while the load is outstanding
    always_ff @(posedge i_clk) begin
        if (wb_flush) begin
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_reg_write  <= mem_reg_write;
            wb_mem_to_reg <= mem_mem_to_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_alu_result <= mem_alu_result;
        wb_load_data  <= i_data_in;
        wb_rd_addr    <= mem_rd_addr;
    end

    assign wb_result = wb_mem_to_reg ? wb_load_data : wb_alu_result;

    // Core outputs
    assign o_pc_out    = pc_q;
    assign o_store_req = mem_mem_write;
    assign o_load_req  = mem_mem_to_reg;
    assign o_data_addr = mem_alu_result;
    assign o_data_out  = mem_rs2_val;

endmodule

`default_nettype wire

// File: source/rv_alu.sv
/* Integer ALU
   Arithmetic, logic, shifts, compares and return address generation */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire  [rv_pkg::xlen-1:0] i_a,
    input  wire  [rv_pkg::xlen-1:0] i_b,
    input  wire  rv_pkg::alu_op_e   i_op,
    output logic [rv_pkg::xlen-1:0] o_result
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            alu_add:    o_result = i_a + i_b;
            alu_sub:    o_result = i_a - i_b;
            alu_and:    o_result = i_a & i_b;
            alu_or:     o_result = i_a | i_b;
            alu_xor:    o_result = i_a ^ i_b;
            alu_slt:    o_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   o_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:    o_result = i_a << shamt;
            alu_srl:    o_result = i_a >> shamt;
            alu_sra:    o_result = $unsigned($signed(i_a) >>> shamt);
            alu_pass_b: o_result = i_b;
            // Address of the next sequential instruction
            alu_link:   o_result = i_a + xlen'(4);
            default:    o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
/* Integer register file, two read ports and one write port, x0 reads as zero */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                               i_clk,
    input  wire                               i_write_en,
    input  wire  [rv_pkg::reg_addr_width-1:0] i_rd_addr,
    input  wire  [rv_pkg::xlen-1:0]           i_rd_data,
    input  wire  [rv_pkg::reg_addr_width-1:0] i_rs1_addr,
    input  wire  [rv_pkg::reg_addr_width-1:0] i_rs2_addr,
    output logic [rv_pkg::xlen-1:0]           o_rs1_data,
    output logic [rv_pkg::xlen-1:0]           o_rs2_data
);
    import rv_pkg::*;

    // Registers x1..x31
    logic [xlen-1:0] regs [31:1];

    always_ff @(posedge i_clk) begin
        if (i_write_en && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: source/rv_decoder.sv
/* RV32I instruction decoder
   Control fields, register addresses and sign-extended immediate */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire  [rv_pkg::instr_width-1:0]    i_instr,
    output rv_pkg::alu_op_e                   o_alu_op,
    output logic                              o_src_a_pc,
    output logic                              o_src_b_imm,
    output logic                              o_reg_write,
    output logic                              o_mem_write,
    output logic                              o_mem_to_reg,
    output logic                              o_branch,
    output logic                              o_branch_ne,
    output logic                              o_jump,
    output logic                              o_jalr,
    output logic [rv_pkg::xlen-1:0]           o_imm,
    output logic [rv_pkg::reg_addr_width-1:0] o_rs1_addr,
    output logic [rv_pkg::reg_addr_width-1:0] o_rs2_addr,
    output logic [rv_pkg::reg_addr_width-1:0] o_rd_addr
);
    import rv_pkg::*;

    opcode_e          opcode;
    alu_op_e          arith_op;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             reg_write;
    logic [xlen-1:0]  imm_i;
    logic [xlen-1:0]  imm_s;
    logic [xlen-1:0]  imm_b;
    logic [xlen-1:0]  imm_u;
    logic [xlen-1:0]  imm_j;

    assign opcode     = opcode_e'(i_instr[6:0]);
    assign funct3     = i_instr[14:12];
    assign funct7     = i_instr[31:25];
    assign o_rd_addr  = i_instr[11:7];
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // Register and immediate arithmetic share funct3
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        o_alu_op     = alu_add;
        o_src_a_pc   = 1'b0;
        o_src_b_imm  = 1'b0;
        reg_write    = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_branch     = 1'b0;
        o_branch_ne  = 1'b0;
        o_jump       = 1'b0;
        o_jalr       = 1'b0;
        o_imm        = imm_i;
        case (opcode)
            op_reg: begin
                o_alu_op  = arith_op;
                reg_write = 1'b1;
            end
            op_imm: begin
                o_alu_op    = arith_op;
                o_src_b_imm = 1'b1;
                reg_write   = 1'b1;
            end
            op_lui: begin
                o_alu_op    = alu_pass_b;
                o_src_b_imm = 1'b1;
                o_imm       = imm_u;
                reg_write   = 1'b1;
            end
            op_load: begin
                o_src_b_imm  = 1'b1;
                o_mem_to_reg = 1'b1;
                reg_write    = 1'b1;
            end
            op_store: begin
                o_src_b_imm = 1'b1;
                o_mem_write = 1'b1;
                o_imm       = imm_s;
            end
            op_branch: begin
                // Only BEQ and BNE
                o_alu_op    = alu_sub;
                o_branch    = (funct3[2:1] == 2'b00);
                o_branch_ne = funct3[0];
                o_imm       = imm_b;
            end
            op_jal: begin
                o_alu_op   = alu_link;
                o_src_a_pc = 1'b1;
                o_jump     = 1'b1;
                o_imm      = imm_j;
                reg_write  = 1'b1;
            end
            op_jalr: begin
                o_alu_op   = alu_link;
                o_src_a_pc = 1'b1;
                o_jump     = 1'b1;
                o_jalr     = 1'b1;
                reg_write  = 1'b1;
            end
            default: ;
        endcase
    end

    // x0 is never a write target
    assign o_reg_write = reg_write && (o_rd_addr != '0);

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
/* RV32I core shared definitions
   Datapath widths, reset address, NOP encoding, opcode and ALU operation types */
`default_nettype none

package rv_pkg;

    // Datapath widths
    localparam int xlen           = 32;
    localparam int instr_width    = 32;
    localparam int reg_addr_width = 5;

    // First fetch address after reset
    localparam logic [xlen-1:0] pc_start = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam logic [instr_width-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_pass_b = 4'd10,   // LUI result
        alu_link   = 4'd11    // Return address for JAL/JALR
    } alu_op_e;

endpackage

`default_nettype wire
